// ==== Makefile ====
TOP := avr_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f avr_core.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== avr_core.f ====
+incdir+include
verilog/avr_isa_pkg.sv
verilog/avr_core_pkg.sv
verilog/stage_control.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_ram.sv
verilog/avr_core.sv
sim/avr_core_sva.sv
sim/avr_core_tb.sv

// ==== include/avr_core_settings.svh ====
`ifndef AVR_CORE_SETTINGS_SVH
`define AVR_CORE_SETTINGS_SVH

// register file and data bus width
`define DATA_WIDTH 8

// r0 to r31
`define R_ADDR_WIDTH 5

// the program counter addresses one word per instruction
`define I_ADDR_WIDTH 8

// data space seen by LDS, STS and the Y pointer
`define D_ADDR_WIDTH 8

// the RAM window starts above the register and I/O area of a real part
`define RAM_BASE 64

// number of bytes in the RAM window
`define RAM_DEPTH 64

`endif

// ==== sim/avr_core_sva.sv ====
`timescale 1ns/1ps

module avr_core_sva (
    input logic                                clk,
    input logic                                reset,
    input avr_core_pkg::stage_e                debug_stage,
    input avr_core_pkg::pc_t                   debug_pc,
    input logic                                debug_wb_we,
    input logic                                ram_we,
    input logic [avr_core_pkg::FLAG_COUNT-1:0] debug_flags
);
    import avr_core_pkg::*;

    if_to_id: assert property (@(posedge clk) disable iff (reset)
        debug_stage == STAGE_IF |=> debug_stage == STAGE_ID)
        else $error("stage IF was not followed by ID");
    id_to_ex: assert property (@(posedge clk) disable iff (reset)
        debug_stage == STAGE_ID |=> debug_stage == STAGE_EX)
        else $error("stage ID was not followed by EX");
    ex_to_mem: assert property (@(posedge clk) disable iff (reset)
        debug_stage == STAGE_EX |=> debug_stage == STAGE_MEM)
        else $error("stage EX was not followed by MEM");
    mem_to_wb: assert property (@(posedge clk) disable iff (reset)
        debug_stage == STAGE_MEM |=> debug_stage == STAGE_WB)
        else $error("stage MEM was not followed by WB");
    wb_to_if: assert property (@(posedge clk) disable iff (reset)
        debug_stage == STAGE_WB |=> debug_stage == STAGE_IF)
        else $error("stage WB was not followed by IF");

    // pc moves only on the edge that ends WB
    pc_hold: assert property (@(posedge clk) disable iff (reset)
        !$stable(debug_pc) |-> $past(debug_stage) == STAGE_WB)
        else $error("pc changed outside the end of WB");

    wb_we_in_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb_we |-> debug_stage == STAGE_WB)
        else $error("register write enable high outside WB");

    ram_we_in_mem: assert property (@(posedge clk) disable iff (reset)
        ram_we |-> debug_stage == STAGE_MEM)
        else $error("RAM write enable high outside MEM");

    flags_after_ex: assert property (@(posedge clk) disable iff (reset)
        !$stable(debug_flags) |-> $past(debug_stage) == STAGE_EX)
        else $error("flags changed outside the cycle after EX");

endmodule

bind avr_core avr_core_sva i_avr_core_sva (
    .clk(clk), .reset(reset), .debug_stage(debug_stage), .debug_pc(debug_pc),
    .debug_wb_we(debug_wb_we), .ram_we(ram_we), .debug_flags(debug_flags)
);

// ==== sim/avr_core_tb.sv ====
`timescale 1ns/1ps
`include "avr_core_settings.svh"

module avr_core_tb;
    import avr_core_pkg::*;
    import avr_isa_pkg::*;

    localparam int PROG_LEN   = 23;
    localparam int RETIRE_END = 26;
    localparam int MAX_CYCLES = 5 * RETIRE_END * 2 + 40;

    logic                  clk;
    logic                  reset;
    logic                  prog_we;
    pc_t                   prog_addr;
    instr_t                prog_data;
    stage_e                debug_stage;
    pc_t                   debug_pc;
    bus_addr_t             debug_bus_address;
    data_t                 debug_wb_value;
    logic                  debug_wb_we;
    reg_addr_t             debug_rd_addr;
    logic [FLAG_COUNT-1:0] debug_flags;

    instr_t                program_words [PROG_LEN];
    data_t                 m_regs [32];
    data_t                 m_ram [`RAM_DEPTH];
    pc_t                   m_pc;
    pc_t                   m_next_pc;
    logic [FLAG_COUNT-1:0] m_flags;
    logic [FLAG_COUNT-1:0] exp_flags;
    logic                  exp_we;
    reg_addr_t             exp_rd;
    data_t                 exp_val;
    logic                  exp_bus;
    bus_addr_t             exp_addr;
    int                    m_stage;
    int                    retired;
    int                    cycles;
    int                    err_count;

    avr_core i_avr_core (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .debug_stage(debug_stage), .debug_pc(debug_pc),
        .debug_bus_address(debug_bus_address), .debug_wb_value(debug_wb_value),
        .debug_wb_we(debug_wb_we), .debug_rd_addr(debug_rd_addr), .debug_flags(debug_flags)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        err_count++;
    endtask

    function automatic instr_t ldi_word(input reg_addr_t d, input data_t k);
        return {4'he, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic logic in_ram(input logic [15:0] addr);
        return addr >= `RAM_BASE && addr < `RAM_BASE + `RAM_DEPTH;
    endfunction

    // the reference model executes one whole instruction at a time
    task automatic execute_instruction(input instr_t w);
        reg_addr_t   d;
        reg_addr_t   r;
        logic [6:0]  k;
        logic [15:0] y;
        logic [8:0]  sum;
        d = w[8:4];
        r = {w[9], w[3:0]};
        k = {w[10:8], w[3:0]};
        y = {m_regs[29], m_regs[28]};
        exp_we = 1'b0;
        exp_rd = d;
        exp_val = '0;
        exp_bus = 1'b0;
        exp_addr = '0;
        exp_flags = m_flags;
        m_next_pc = m_pc + 8'd1;
        casez (w)
            16'b1110_????_????_????: begin
                exp_we = 1'b1;
                exp_rd = {1'b1, w[7:4]};
                exp_val = {w[11:8], w[3:0]};
            end
            16'b0010_11??_????_????: begin
                exp_we = 1'b1;
                exp_val = m_regs[r];
            end
            16'b0000_11??_????_????: begin
                sum = m_regs[d] + m_regs[r];
                exp_we = 1'b1;
                exp_val = sum[7:0];
                exp_flags[FLAG_Z] = (sum[7:0] == 8'd0);
                exp_flags[FLAG_C] = sum[8];
            end
            16'b1010_0???_????_????: begin
                exp_we = 1'b1;
                exp_rd = {1'b1, w[7:4]};
                exp_bus = 1'b1;
                exp_addr = bus_addr_t'(`RAM_BASE + k[5:0]);
                exp_val = m_ram[exp_addr - `RAM_BASE];
            end
            16'b1010_1???_????_????: begin
                exp_bus = 1'b1;
                exp_addr = bus_addr_t'(`RAM_BASE + k[5:0]);
                m_ram[exp_addr - `RAM_BASE] = m_regs[{1'b1, w[7:4]}];
            end
            16'b1000_000?_????_1000: begin
                exp_we = 1'b1;
                exp_bus = (y < 16'd256);
                exp_addr = y[7:0];
                exp_val = in_ram(y) ? m_ram[y - `RAM_BASE] : 8'd0;
            end
            16'b1000_001?_????_1000: begin
                exp_bus = (y < 16'd256);
                exp_addr = y[7:0];
                if (in_ram(y)) begin
                    m_ram[y - `RAM_BASE] = m_regs[d];
                end
            end
            16'b1100_????_????_????: begin
                m_next_pc = m_pc + 8'd1 + w[7:0];
            end
            default: begin
                exp_we = 1'b0;
            end
        endcase
        if (exp_we) begin
            m_regs[exp_rd] = exp_val;
        end
    endtask

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (debug_stage === stage_e'(m_stage))
                else report_mismatch("debug_stage", 16'(m_stage), 16'(debug_stage));
            assert (debug_pc === m_pc) else report_mismatch("debug_pc", m_pc, debug_pc);
            assert (debug_flags === m_flags)
                else report_mismatch("debug_flags", m_flags, debug_flags);
            if (m_stage == 0) begin
                assert (debug_wb_we === 1'b0)
                    else report_mismatch("debug_wb_we", 16'd0, debug_wb_we);
                execute_instruction(program_words[m_pc]);
            end else if (m_stage == 2) begin
                m_flags = exp_flags;
            end else if (m_stage == 3 && exp_bus) begin
                assert (debug_bus_address === exp_addr)
                    else report_mismatch("debug_bus_address", exp_addr, debug_bus_address);
            end else if (m_stage == 4) begin
                assert (debug_wb_we === exp_we)
                    else report_mismatch("debug_wb_we", exp_we, debug_wb_we);
                if (exp_we) begin
                    assert (debug_rd_addr === exp_rd)
                        else report_mismatch("debug_rd_addr", exp_rd, debug_rd_addr);
                    assert (debug_wb_value === exp_val)
                        else report_mismatch("debug_wb_value", exp_val, debug_wb_value);
                end
                // r30 and r31 are only loaded by the words the RJMP skips
                assert (!(debug_wb_we && debug_rd_addr >= 5'd30)) else begin
                    $display("t=%0t a skipped instruction wrote a register", $time);
                    err_count++;
                end
                m_pc = m_next_pc;
                retired++;
            end
            m_stage = (m_stage + 1) % 5;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles before the program finished", cycles);
            $display("errors: %0d", err_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf478_96a0));
        clk = 1'b0;
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        err_count = 0;
        cycles = 0;
        retired = 0;
        m_stage = 0;
        m_pc = '0;
        m_flags = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            m_ram[i] = '0;
        end
        program_words[0]  = ldi_word(5'd16, 8'hc8);
        program_words[1]  = ldi_word(5'd17, 8'h50);
        program_words[2]  = 16'h0f01;  // add r16, r17 with carry out
        program_words[3]  = ldi_word(5'd18, data_t'($urandom));
        program_words[4]  = 16'ha825;  // sts 69, r18
        program_words[5]  = 16'ha035;  // lds r19, 69
        program_words[6]  = 16'h2f43;  // mov r20, r19
        program_words[7]  = ldi_word(5'd28, 8'h48);
        program_words[8]  = ldi_word(5'd29, 8'h00);
        program_words[9]  = ldi_word(5'd21, data_t'($urandom));
        program_words[10] = 16'h8358;  // st Y, r21
        program_words[11] = 16'h8168;  // ld r22, Y
        program_words[12] = 16'ha078;  // lds r23, 72
        program_words[13] = ldi_word(5'd28, 8'h10);
        program_words[14] = 16'h8188;  // ld r24, Y below the RAM
        program_words[15] = ldi_word(5'd25, 8'h80);
        program_words[16] = ldi_word(5'd26, 8'h80);
        program_words[17] = 16'h0f9a;  // add r25, r26 gives zero and carry
        program_words[18] = 16'hc002;
        program_words[19] = ldi_word(5'd30, 8'haa);
        program_words[20] = ldi_word(5'd31, 8'h55);
        program_words[21] = 16'h0f02;  // add r16, r18
        program_words[22] = 16'hcfff;
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= pc_t'(i);
            prog_data <= program_words[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait (retired >= RETIRE_END);
        @(posedge clk);
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                                clk,
    input  logic                                reset,
    input  avr_isa_pkg::opcode_e                opcode,
    input  avr_core_pkg::data_t                 a,
    input  avr_core_pkg::data_t                 b,
    input  avr_isa_pkg::imm_t                   imm,
    input  avr_core_pkg::data_t                 load_data,
    input  logic                                update,
    output avr_core_pkg::data_t                 result,
    output logic [avr_core_pkg::FLAG_COUNT-1:0] flags
);
    import avr_core_pkg::*;
    import avr_isa_pkg::*;

    data_t sum;
    logic  carry;

    assign {carry, sum} = a + b;

    always_comb begin
        case (opcode)
            OP_LDI:          result = imm;
            OP_MOV:          result = b;
            OP_ADD:          result = sum;
            OP_LDS, OP_LD_Y: result = load_data;
            default:         result = '0;
        endcase
    end

    // only ADD touches SREG in this subset
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (update && opcode == OP_ADD) begin
            flags[FLAG_Z] <= (sum == '0);
            flags[FLAG_C] <= carry;
        end
    end

endmodule

// ==== verilog/avr_core.sv ====
`timescale 1ns/1ps
`include "avr_core_settings.svh"

module avr_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                prog_we,
    input  avr_core_pkg::pc_t                   prog_addr,
    input  avr_isa_pkg::instr_t                 prog_data,
    output avr_core_pkg::stage_e                debug_stage,
    output avr_core_pkg::pc_t                   debug_pc,
    output avr_core_pkg::bus_addr_t             debug_bus_address,
    output avr_core_pkg::data_t                 debug_wb_value,
    output logic                                debug_wb_we,
    output avr_core_pkg::reg_addr_t             debug_rd_addr,
    output logic [avr_core_pkg::FLAG_COUNT-1:0] debug_flags
);
    import avr_core_pkg::*;
    import avr_isa_pkg::*;

    localparam int K_BITS = $clog2(`RAM_DEPTH);

    stage_e      stage;
    pc_t         pc;
    instr_t      instr;
    opcode_e     opcode;
    reg_addr_t   rd_addr;
    reg_addr_t   rr_addr;
    imm_t        imm;
    logic        rd_we;
    logic        mem_we;
    logic [11:0] jump_offset;
    data_t       rd_data;
    data_t       rr_data;
    data_t [1:0] y_pair;
    data_t       alu_out;
    logic [FLAG_COUNT-1:0] flags;
    data_t       ram_rdata;
    bus_addr_t   bus_addr;
    logic        reg_we;
    logic        ram_we;

    // a Y value above the 8-bit data space lands on address 0, outside the RAM
    always_comb begin
        case (opcode)
            OP_LDS, OP_STS:   bus_addr = bus_addr_t'(`RAM_BASE) + bus_addr_t'(imm[K_BITS-1:0]);
            OP_LD_Y, OP_ST_Y: bus_addr = (y_pair[1] == '0) ? y_pair[0] : '0;
            default:          bus_addr = '0;
        endcase
    end

    assign reg_we = rd_we && (stage == STAGE_WB);
    assign ram_we = mem_we && (stage == STAGE_MEM);

    stage_control i_stage_control (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .jump_taken(opcode == OP_RJMP), .jump_offset(jump_offset),
        .stage(stage), .pc(pc), .instr(instr)
    );

    instr_decode i_instr_decode (
        .instr(instr), .opcode(opcode), .rd_addr(rd_addr), .rr_addr(rr_addr),
        .imm(imm), .rd_we(rd_we), .mem_we(mem_we), .jump_offset(jump_offset)
    );

    reg_file i_reg_file (
        .clk(clk), .reset(reset), .rd_addr(rd_addr), .rr_addr(rr_addr), .we(reg_we),
        .wdata(alu_out), .rd_data(rd_data), .rr_data(rr_data), .y_pair(y_pair)
    );

    alu i_alu (
        .clk(clk), .reset(reset), .opcode(opcode), .a(rd_data), .b(rr_data), .imm(imm),
        .load_data(ram_rdata), .update(stage == STAGE_EX), .result(alu_out), .flags(flags)
    );

    // store data comes from the d field register
    data_ram i_data_ram (
        .clk(clk), .reset(reset), .addr(bus_addr), .we(ram_we), .wdata(rd_data),
        .rdata(ram_rdata)
    );

    assign debug_stage       = stage;
    assign debug_pc          = pc;
    assign debug_bus_address = bus_addr;
    assign debug_wb_value    = alu_out;
    assign debug_wb_we       = reg_we;
    assign debug_rd_addr     = rd_addr;
    assign debug_flags       = flags;

endmodule

// ==== verilog/avr_core_pkg.sv ====
`include "avr_core_settings.svh"

package avr_core_pkg;

    // one instruction walks through all five, one cycle each
    typedef enum logic [2:0] {
        STAGE_IF,
        STAGE_ID,
        STAGE_EX,
        STAGE_MEM,
        STAGE_WB
    } stage_e;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef logic [`R_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [`I_ADDR_WIDTH-1:0] pc_t;

    typedef logic [`D_ADDR_WIDTH-1:0] bus_addr_t;

    // only Z and C are kept from SREG
    localparam int FLAG_COUNT = 2;
    localparam int FLAG_Z     = 0;
    localparam int FLAG_C     = 1;

endpackage

// ==== verilog/avr_isa_pkg.sv ====
`include "avr_core_settings.svh"

package avr_isa_pkg;

    typedef logic [15:0] instr_t;

    typedef logic [`DATA_WIDTH-1:0] imm_t;

    // everything outside these operations runs as a NOP
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LDI,
        OP_MOV,
        OP_ADD,
        OP_LDS,
        OP_STS,
        OP_LD_Y,
        OP_ST_Y,
        OP_RJMP
    } opcode_e;

    // mask and match pairs taken from the AVR opcode map
    localparam instr_t LDI_MASK   = 16'hf000;
    localparam instr_t LDI_MATCH  = 16'he000;
    localparam instr_t MOV_MASK   = 16'hfc00;
    localparam instr_t MOV_MATCH  = 16'h2c00;
    localparam instr_t ADD_MASK   = 16'hfc00;
    localparam instr_t ADD_MATCH  = 16'h0c00;

    // the 16-bit LDS and STS of the reduced core only reach r16 to r31
    localparam instr_t LDS_MASK   = 16'hf800;
    localparam instr_t LDS_MATCH  = 16'ha000;
    localparam instr_t STS_MASK   = 16'hf800;
    localparam instr_t STS_MATCH  = 16'ha800;

    localparam instr_t LD_Y_MASK  = 16'hfe0f;
    localparam instr_t LD_Y_MATCH = 16'h8008;
    localparam instr_t ST_Y_MASK  = 16'hfe0f;
    localparam instr_t ST_Y_MATCH = 16'h8208;
    localparam instr_t RJMP_MASK  = 16'hf000;
    localparam instr_t RJMP_MATCH = 16'hc000;

endpackage

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps
`include "avr_core_settings.svh"

module data_ram (
    input  logic                    clk,
    input  logic                    reset,
    input  avr_core_pkg::bus_addr_t addr,
    input  logic                    we,
    input  avr_core_pkg::data_t     wdata,
    output avr_core_pkg::data_t     rdata
);
    import avr_core_pkg::*;

    localparam int IDX_WIDTH = $clog2(`RAM_DEPTH);

    data_t     mem [`RAM_DEPTH];
    bus_addr_t offset;
    logic      in_window;

    assign offset    = addr - bus_addr_t'(`RAM_BASE);
    assign in_window = (addr >= bus_addr_t'(`RAM_BASE)) && (offset < `RAM_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we && in_window) begin
            mem[offset[IDX_WIDTH-1:0]] <= wdata;
        end
    end

    // nothing is mapped outside the window, so it reads as zero
    assign rdata = in_window ? mem[offset[IDX_WIDTH-1:0]] : '0;

endmodule

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  avr_isa_pkg::instr_t     instr,
    output avr_isa_pkg::opcode_e    opcode,
    output avr_core_pkg::reg_addr_t rd_addr,
    output avr_core_pkg::reg_addr_t rr_addr,
    output avr_isa_pkg::imm_t       imm,
    output logic                    rd_we,
    output logic                    mem_we,
    output logic [11:0]             jump_offset
);
    import avr_isa_pkg::*;

    always_comb begin
        opcode = OP_NOP;
        if ((instr & LDI_MASK) == LDI_MATCH) begin
            opcode = OP_LDI;
        end else if ((instr & MOV_MASK) == MOV_MATCH) begin
            opcode = OP_MOV;
        end else if ((instr & ADD_MASK) == ADD_MATCH) begin
            opcode = OP_ADD;
        end else if ((instr & LDS_MASK) == LDS_MATCH) begin
            opcode = OP_LDS;
        end else if ((instr & STS_MASK) == STS_MATCH) begin
            opcode = OP_STS;
        end else if ((instr & LD_Y_MASK) == LD_Y_MATCH) begin
            opcode = OP_LD_Y;
        end else if ((instr & ST_Y_MASK) == ST_Y_MATCH) begin
            opcode = OP_ST_Y;
        end else if ((instr & RJMP_MASK) == RJMP_MATCH) begin
            opcode = OP_RJMP;
        end
    end

    // the 4-bit d field of LDI, LDS and STS only reaches r16 to r31
    always_comb begin
        case (opcode)
            OP_LDI, OP_LDS, OP_STS: begin
                rd_addr = {1'b1, instr[7:4]};
            end
            default: begin
                rd_addr = instr[8:4];
            end
        endcase
    end

    assign rr_addr = {instr[9], instr[3:0]};

    // k keeps all seven bits here, the top level folds it into the RAM window
    always_comb begin
        case (opcode)
            OP_LDI: begin
                imm = {instr[11:8], instr[3:0]};
            end
            OP_LDS, OP_STS: begin
                imm = {1'b0, instr[10:8], instr[3:0]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        rd_we  = 1'b0;
        mem_we = 1'b0;
        case (opcode)
            OP_LDI, OP_MOV, OP_ADD, OP_LDS, OP_LD_Y: begin
                rd_we = 1'b1;
            end
            OP_STS, OP_ST_Y: begin
                mem_we = 1'b1;
            end
            default: begin
                rd_we  = 1'b0;
                mem_we = 1'b0;
            end
        endcase
    end

    assign jump_offset = instr[11:0];

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "avr_core_settings.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  avr_core_pkg::reg_addr_t       rd_addr,
    input  avr_core_pkg::reg_addr_t       rr_addr,
    input  logic                          we,
    input  avr_core_pkg::data_t           wdata,
    output avr_core_pkg::data_t           rd_data,
    output avr_core_pkg::data_t           rr_data,
    output avr_core_pkg::data_t [1:0]     y_pair
);
    import avr_core_pkg::*;

    localparam int REG_COUNT = 2 ** `R_ADDR_WIDTH;

    // Y is r29:r28
    localparam reg_addr_t Y_LOW  = 5'd28;
    localparam reg_addr_t Y_HIGH = 5'd29;

    data_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd_addr] <= wdata;
        end
    end

    assign rd_data = regs[rd_addr];
    assign rr_data = regs[rr_addr];

    assign y_pair[1] = regs[Y_HIGH];
    assign y_pair[0] = regs[Y_LOW];

endmodule

// ==== verilog/stage_control.sv ====
`timescale 1ns/1ps
`include "avr_core_settings.svh"

module stage_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prog_we,
    input  avr_core_pkg::pc_t    prog_addr,
    input  avr_isa_pkg::instr_t  prog_data,
    input  logic                 jump_taken,
    input  logic [11:0]          jump_offset,
    output avr_core_pkg::stage_e stage,
    output avr_core_pkg::pc_t    pc,
    output avr_isa_pkg::instr_t  instr
);
    import avr_core_pkg::*;
    import avr_isa_pkg::*;

    localparam int PROG_DEPTH = 2 ** `I_ADDR_WIDTH;

    instr_t      prog_mem [PROG_DEPTH];
    stage_e      stage_next;
    logic [11:0] pc_step;
    logic [11:0] pc_wide;

    always_comb begin
        case (stage)
            STAGE_IF: begin
                stage_next = STAGE_ID;
            end
            STAGE_ID: begin
                stage_next = STAGE_EX;
            end
            STAGE_EX: begin
                stage_next = STAGE_MEM;
            end
            STAGE_MEM: begin
                stage_next = STAGE_WB;
            end
            default: begin
                stage_next = STAGE_IF;
            end
        endcase
    end

    // RJMP offset is signed 12 bits, the sum wraps modulo the program size
    assign pc_step = jump_taken ? jump_offset + 12'd1 : 12'd1;
    assign pc_wide = 12'(pc) + pc_step;

    // loaded by the testbench while reset is held
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IF;
        end else begin
            stage <= stage_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (stage == STAGE_IF) begin
                instr <= prog_mem[pc];
            end
            // pc holds through the whole instruction and moves when WB ends
            if (stage == STAGE_WB) begin
                pc <= pc_t'(pc_wide);
            end
        end
    end

endmodule
